// ==== compile.f ====
src/icache_pkg.sv
src/icache_way_ram.sv
src/icache_addr_decode.sv
src/icache_hit_ctrl.sv
src/icache_word_select.sv
src/icache_top.sv
verification/icache_tb_mem.sv
verification/icache_tb.sv

// ==== src/icache_addr_decode.sv ====
`timescale 1ns/1ps

module icache_addr_decode #(
    parameter  int INDEX_W = 7,
    localparam int TAG_W   = 32 - INDEX_W - icache_pkg::OFFSET_W
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           fetch_en_i,
    input  icache_pkg::addr_t              fetch_pc_i,
    input  logic                           fetch_uncache_i,
    input  logic                           stall_i,
    input  logic                           hold_i,
    input  logic                           flush_i,
    input  logic                           cacop_en_i,
    input  icache_pkg::addr_t              cacop_addr_i,
    output logic                           lk_valid_o,
    output logic                           lk_uncache_o,
    output icache_pkg::addr_t              lk_pc_o,
    output logic [TAG_W-1:0]               lk_tag_o,
    output logic [INDEX_W-1:0]             lk_index_o,
    output logic [icache_pkg::OFFSET_W-1:0] lk_offset_o,
    output logic [INDEX_W-1:0]             ram_index_o,
    output logic [INDEX_W-1:0]             cacop_index_o
);

    localparam int IDX_LO = icache_pkg::OFFSET_W;

    logic accept;

    assign accept = fetch_en_i && !stall_i;

    // lookup stage valid
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            lk_valid_o <= 1'b0;
        end else if (!hold_i) begin
            lk_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i && accept) begin
            lk_pc_o      <= fetch_pc_i;
            lk_uncache_o <= fetch_uncache_i;
        end
    end

    assign lk_tag_o    = lk_pc_o[31:IDX_LO+INDEX_W];
    assign lk_index_o  = lk_pc_o[IDX_LO +: INDEX_W];
    assign lk_offset_o = lk_pc_o[IDX_LO-1:0];

    // keep reading the held set so the tags are fresh once the hold ends
    assign ram_index_o = hold_i ? lk_index_o : fetch_pc_i[IDX_LO +: INDEX_W];

    always_ff @(posedge clk) begin
        if (cacop_en_i && !stall_i) begin
            cacop_index_o <= cacop_addr_i[IDX_LO +: INDEX_W];
        end
    end

endmodule

// ==== src/icache_hit_ctrl.sv ====
`timescale 1ns/1ps

module icache_hit_ctrl #(
    parameter  int INDEX_W = 7,
    localparam int TAG_W   = 32 - INDEX_W - icache_pkg::OFFSET_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush_i,
    input  logic                    lk_valid_i,
    input  logic                    lk_uncache_i,
    input  icache_pkg::addr_t       lk_pc_i,
    input  logic [TAG_W-1:0]        lk_tag_i,
    input  logic [INDEX_W-1:0]      lk_index_i,
    input  logic                    cacop_en_i,
    input  icache_pkg::cacop_mode_t cacop_mode_i,
    input  logic [INDEX_W-1:0]      cacop_index_i,
    input  logic                    way0_valid_i,
    input  logic [TAG_W-1:0]        way0_tag_i,
    input  logic                    way1_valid_i,
    input  logic [TAG_W-1:0]        way1_tag_i,
    input  logic                    ret_valid_i,
    input  logic                    uc_rvalid_i,
    output logic                    rd_req_o,
    output icache_pkg::addr_t       rd_addr_o,
    output logic                    uc_ren_o,
    output icache_pkg::addr_t       uc_addr_o,
    output logic                    stall_o,
    output logic                    hold_o,
    output logic                    wr_en0_o,
    output logic                    wr_en1_o,
    output logic [INDEX_W-1:0]      wr_index_o,
    output logic                    wr_valid_o,
    output logic                    hit_o,
    output logic                    hit_way_o,
    output logic                    refill_done_o,
    output logic                    uc_done_o
);

    localparam int SETS = 1 << INDEX_W;

    icache_pkg::ctrl_state_t state_q;
    icache_pkg::ctrl_state_t state_n;
    logic [SETS-1:0] lru_q;             // way to replace next, per set
    logic discard_q;
    logic tail_q;
    logic hit0;
    logic hit1;
    logic lookup;
    logic hit_any;
    logic miss;
    logic unc_go;
    logic cacop_go;
    logic ret_ok;
    logic uc_ok;
    logic lru_way;

    assign hit0    = way0_valid_i && (way0_tag_i == lk_tag_i);
    assign hit1    = way1_valid_i && (way1_tag_i == lk_tag_i);
    assign lookup  = (state_q == icache_pkg::LOOKUP) && lk_valid_i;
    assign hit_any = lookup && !lk_uncache_i && (hit0 || hit1);
    assign miss    = lookup && !lk_uncache_i && !(hit0 || hit1);
    assign unc_go  = lookup && lk_uncache_i;

    assign ret_ok  = ret_valid_i && !discard_q;
    assign uc_ok   = uc_rvalid_i && !discard_q;
    assign lru_way = lru_q[lk_index_i];

    assign stall_o  = (state_q != icache_pkg::LOOKUP) || miss || unc_go || tail_q || discard_q;
    assign cacop_go = cacop_en_i && (cacop_mode_i != 2'd3) && !stall_o;  // mode 3 is a no-op

    // freeze the lookup address until the request is answered
    assign hold_o = miss || unc_go
                 || (state_q == icache_pkg::MISS_WAIT && !ret_ok)
                 || (state_q == icache_pkg::UNC_WAIT && !uc_ok)
                 || (state_q == icache_pkg::CACOP);

    always_comb begin
        state_n = state_q;
        case (state_q)
            icache_pkg::LOOKUP: begin
                if (cacop_go) begin
                    state_n = icache_pkg::CACOP;
                end else if (unc_go) begin
                    state_n = icache_pkg::UNC_WAIT;
                end else if (miss) begin
                    state_n = icache_pkg::MISS_WAIT;
                end
            end
            icache_pkg::MISS_WAIT: if (ret_ok) state_n = icache_pkg::LOOKUP;
            icache_pkg::UNC_WAIT:  if (uc_ok) state_n = icache_pkg::LOOKUP;
            default:               state_n = icache_pkg::LOOKUP;
        endcase
        if (flush_i && !cacop_go) begin
            state_n = icache_pkg::LOOKUP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= icache_pkg::LOOKUP;
        end else begin
            state_q <= state_n;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (hit_any && !flush_i) begin
            lru_q[lk_index_i] <= !hit1;
        end else if (refill_done_o) begin
            lru_q[lk_index_i] <= !lru_way;
        end
    end

    // one late return belongs to a killed request
    always_ff @(posedge clk) begin
        if (reset) begin
            discard_q <= 1'b0;
        end else if (flush_i && ((state_q == icache_pkg::MISS_WAIT && !ret_valid_i)
                              || (state_q == icache_pkg::UNC_WAIT && !uc_rvalid_i))) begin
            discard_q <= 1'b1;
        end else if (ret_valid_i || uc_rvalid_i) begin
            discard_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tail_q <= 1'b0;
        end else begin
            tail_q <= refill_done_o || uc_done_o;  // extra stall cycle after a fill
        end
    end

    assign rd_req_o      = state_q == icache_pkg::MISS_WAIT;
    assign rd_addr_o     = {lk_pc_i[31:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
    assign uc_ren_o      = state_q == icache_pkg::UNC_WAIT;
    assign uc_addr_o     = lk_pc_i;
    assign refill_done_o = (state_q == icache_pkg::MISS_WAIT) && ret_ok;
    assign uc_done_o     = (state_q == icache_pkg::UNC_WAIT) && uc_ok;

    assign wr_en0_o   = (state_q == icache_pkg::CACOP) || (refill_done_o && !lru_way);
    assign wr_en1_o   = (state_q == icache_pkg::CACOP) || (refill_done_o && lru_way);
    assign wr_index_o = (state_q == icache_pkg::CACOP) ? cacop_index_i : lk_index_i;
    assign wr_valid_o = state_q != icache_pkg::CACOP;  // cacop only clears valid

    assign hit_o     = hit_any;
    assign hit_way_o = hit1;

    // a single-way write is a refill of the held cached lookup
    a_one_way_refill: assert property (
        @(posedge clk) disable iff (reset)
        (wr_en0_o != wr_en1_o) |-> lk_valid_i && !lk_uncache_i
    );

    a_return_expected: assert property (
        @(posedge clk) disable iff (reset)
        (ret_valid_i || uc_rvalid_i) |-> discard_q
            || (ret_valid_i && state_q == icache_pkg::MISS_WAIT)
            || (uc_rvalid_i && state_q == icache_pkg::UNC_WAIT)
    );

endmodule

// ==== src/icache_pkg.sv ====
package icache_pkg;

    localparam int OFFSET_W       = 5;
    localparam int WORDS_PER_LINE = 8;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;  // word 0 in the low bits
    typedef logic [1:0] cacop_mode_t;

    // hit controller
    typedef enum logic [1:0] {
        LOOKUP,
        MISS_WAIT,
        UNC_WAIT,
        CACOP
    } ctrl_state_t;

endpackage

// ==== src/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
    parameter  int INDEX_W = 7,
    localparam int TAG_W   = 32 - INDEX_W - icache_pkg::OFFSET_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fetch_en_i,
    input  icache_pkg::addr_t       fetch_pc_i,
    input  logic                    fetch_uncache_i,
    input  logic                    flush_i,
    output logic                    stall_o,
    output logic                    inst_valid_o,
    output icache_pkg::word_t       inst_o,
    output icache_pkg::addr_t       inst_pc_o,
    output logic                    rd_req_o,
    output icache_pkg::addr_t       rd_addr_o,
    input  logic                    ret_valid_i,
    input  icache_pkg::line_t       ret_data_i,
    output logic                    uc_ren_o,
    output icache_pkg::addr_t       uc_addr_o,
    input  logic                    uc_rvalid_i,
    input  icache_pkg::word_t       uc_rdata_i,
    input  logic                    cacop_en_i,
    input  icache_pkg::cacop_mode_t cacop_mode_i,
    input  icache_pkg::addr_t       cacop_addr_i
);

    logic                            lk_valid;
    logic                            lk_uncache;
    icache_pkg::addr_t               lk_pc;
    logic [TAG_W-1:0]                lk_tag;
    logic [INDEX_W-1:0]              lk_index;
    logic [icache_pkg::OFFSET_W-1:0] lk_offset;
    logic [INDEX_W-1:0]              ram_index;
    logic [INDEX_W-1:0]              cacop_index;
    logic                            hold;
    logic                            wr_en0;
    logic                            wr_en1;
    logic [INDEX_W-1:0]              wr_index;
    logic                            wr_valid;
    logic                            hit;
    logic                            hit_way;
    logic                            refill_done;
    logic                            uc_done;
    logic                            way0_valid;
    logic                            way1_valid;
    logic [TAG_W-1:0]                way0_tag;
    logic [TAG_W-1:0]                way1_tag;
    icache_pkg::line_t               way0_line;
    icache_pkg::line_t               way1_line;

    icache_addr_decode #(.INDEX_W(INDEX_W)) addr_decode_inst (
        .clk(clk), .reset(reset),
        .fetch_en_i(fetch_en_i), .fetch_pc_i(fetch_pc_i), .fetch_uncache_i(fetch_uncache_i),
        .stall_i(stall_o), .hold_i(hold), .flush_i(flush_i),
        .cacop_en_i(cacop_en_i), .cacop_addr_i(cacop_addr_i),
        .lk_valid_o(lk_valid), .lk_uncache_o(lk_uncache), .lk_pc_o(lk_pc),
        .lk_tag_o(lk_tag), .lk_index_o(lk_index), .lk_offset_o(lk_offset),
        .ram_index_o(ram_index), .cacop_index_o(cacop_index)
    );

    icache_hit_ctrl #(.INDEX_W(INDEX_W)) hit_ctrl_inst (
        .clk(clk), .reset(reset), .flush_i(flush_i),
        .lk_valid_i(lk_valid), .lk_uncache_i(lk_uncache), .lk_pc_i(lk_pc),
        .lk_tag_i(lk_tag), .lk_index_i(lk_index),
        .cacop_en_i(cacop_en_i), .cacop_mode_i(cacop_mode_i), .cacop_index_i(cacop_index),
        .way0_valid_i(way0_valid), .way0_tag_i(way0_tag),
        .way1_valid_i(way1_valid), .way1_tag_i(way1_tag),
        .ret_valid_i(ret_valid_i), .uc_rvalid_i(uc_rvalid_i),
        .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o),
        .uc_ren_o(uc_ren_o), .uc_addr_o(uc_addr_o),
        .stall_o(stall_o), .hold_o(hold),
        .wr_en0_o(wr_en0), .wr_en1_o(wr_en1), .wr_index_o(wr_index), .wr_valid_o(wr_valid),
        .hit_o(hit), .hit_way_o(hit_way),
        .refill_done_o(refill_done), .uc_done_o(uc_done)
    );

    icache_word_select word_select_inst (
        .clk(clk), .reset(reset), .flush_i(flush_i),
        .hit_i(hit), .hit_way_i(hit_way),
        .refill_done_i(refill_done), .uc_done_i(uc_done),
        .lk_pc_i(lk_pc), .lk_offset_i(lk_offset),
        .way0_line_i(way0_line), .way1_line_i(way1_line),
        .ret_data_i(ret_data_i), .uc_rdata_i(uc_rdata_i),
        .inst_valid_o(inst_valid_o), .inst_o(inst_o), .inst_pc_o(inst_pc_o)
    );

    icache_way_ram #(.INDEX_W(INDEX_W)) way0_inst (
        .clk(clk), .reset(reset), .rd_index_i(ram_index),
        .wr_en_i(wr_en0), .wr_index_i(wr_index), .wr_valid_i(wr_valid),
        .wr_tag_i(lk_tag), .wr_line_i(ret_data_i),
        .rd_valid_o(way0_valid), .rd_tag_o(way0_tag), .rd_line_o(way0_line)
    );

    icache_way_ram #(.INDEX_W(INDEX_W)) way1_inst (
        .clk(clk), .reset(reset), .rd_index_i(ram_index),
        .wr_en_i(wr_en1), .wr_index_i(wr_index), .wr_valid_i(wr_valid),
        .wr_tag_i(lk_tag), .wr_line_i(ret_data_i),
        .rd_valid_o(way1_valid), .rd_tag_o(way1_tag), .rd_line_o(way1_line)
    );

endmodule

// ==== src/icache_way_ram.sv ====
`timescale 1ns/1ps

module icache_way_ram #(
    parameter  int INDEX_W = 7,
    localparam int TAG_W   = 32 - INDEX_W - icache_pkg::OFFSET_W
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [INDEX_W-1:0]  rd_index_i,
    input  logic                wr_en_i,
    input  logic [INDEX_W-1:0]  wr_index_i,
    input  logic                wr_valid_i,
    input  logic [TAG_W-1:0]    wr_tag_i,
    input  icache_pkg::line_t   wr_line_i,
    output logic                rd_valid_o,
    output logic [TAG_W-1:0]    rd_tag_o,
    output icache_pkg::line_t   rd_line_o
);

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]  tag_mem [SETS];
    icache_pkg::line_t line_mem [SETS];
    logic [SETS-1:0]   valid_q;
    logic [INDEX_W-1:0] rd_index_q;

    // tag and line storage, block ram style
    always_ff @(posedge clk) begin
        if (wr_en_i && wr_valid_i) begin
            tag_mem[wr_index_i]  <= wr_tag_i;
            line_mem[wr_index_i] <= wr_line_i;
        end
        rd_tag_o   <= tag_mem[rd_index_i];
        rd_line_o  <= line_mem[rd_index_i];
        rd_index_q <= rd_index_i;
    end

    // valid bits kept in flops so an invalidate is seen on the next read
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_index_i] <= wr_valid_i;
        end
    end

    assign rd_valid_o = valid_q[rd_index_q];

    a_wr_index_known: assert property (
        @(posedge clk) disable iff (reset)
        wr_en_i |-> !$isunknown({wr_index_i, wr_valid_i})
    );

endmodule

// ==== src/icache_word_select.sv ====
`timescale 1ns/1ps

module icache_word_select (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flush_i,
    input  logic                            hit_i,
    input  logic                            hit_way_i,
    input  logic                            refill_done_i,
    input  logic                            uc_done_i,
    input  icache_pkg::addr_t               lk_pc_i,
    input  logic [icache_pkg::OFFSET_W-1:0] lk_offset_i,
    input  icache_pkg::line_t               way0_line_i,
    input  icache_pkg::line_t               way1_line_i,
    input  icache_pkg::line_t               ret_data_i,
    input  icache_pkg::word_t               uc_rdata_i,
    output logic                            inst_valid_o,
    output icache_pkg::word_t               inst_o,
    output icache_pkg::addr_t               inst_pc_o
);

    localparam int SEL_W = $clog2(icache_pkg::WORDS_PER_LINE);

    logic [SEL_W-1:0]  word_sel;
    icache_pkg::line_t hit_line;
    icache_pkg::word_t hit_word;
    icache_pkg::word_t fill_word;
    logic              hit_q;
    icache_pkg::word_t hit_word_q;
    icache_pkg::addr_t hit_pc_q;

    assign word_sel  = lk_offset_i[icache_pkg::OFFSET_W-1:2];
    assign hit_line  = hit_way_i ? way1_line_i : way0_line_i;
    assign hit_word  = hit_line[word_sel*32 +: 32];
    assign fill_word = ret_data_i[word_sel*32 +: 32];  // critical word straight from memory

    // hit pipeline stage
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit_i;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_i) begin
            hit_word_q <= hit_word;
            hit_pc_q   <= lk_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= hit_q || refill_done_i || uc_done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_q) begin
            inst_o    <= hit_word_q;
            inst_pc_o <= hit_pc_q;
        end else if (refill_done_i) begin
            inst_o    <= fill_word;
            inst_pc_o <= lk_pc_i;
        end else if (uc_done_i) begin
            inst_o    <= uc_rdata_i;
            inst_pc_o <= lk_pc_i;
        end
    end

endmodule

// ==== verification/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

    localparam int INDEX_W = 3;
    localparam int SETS    = 1 << INDEX_W;
    localparam int TAG_W   = 32 - INDEX_W - icache_pkg::OFFSET_W;
    localparam int TIMEOUT = 200;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    fetch_en_i;
    icache_pkg::addr_t       fetch_pc_i;
    logic                    fetch_uncache_i;
    logic                    flush_i;
    logic                    stall_o;
    logic                    inst_valid_o;
    icache_pkg::word_t       inst_o;
    icache_pkg::addr_t       inst_pc_o;
    logic                    rd_req_o;
    icache_pkg::addr_t       rd_addr_o;
    logic                    ret_valid_i;
    icache_pkg::line_t       ret_data_i;
    logic                    uc_ren_o;
    icache_pkg::addr_t       uc_addr_o;
    logic                    uc_rvalid_i;
    icache_pkg::word_t       uc_rdata_i;
    logic                    cacop_en_i;
    icache_pkg::cacop_mode_t cacop_mode_i;
    icache_pkg::addr_t       cacop_addr_i;
    logic [2:0]              mem_lat;

    logic [15:0]       lfsr = 16'd61015;
    int                cyc;
    int                res_cyc;
    int                prev_res_cyc;
    logic              rd_seen;
    logic              uc_seen;
    icache_pkg::addr_t rd_seen_addr;
    icache_pkg::addr_t uc_seen_addr;
    icache_pkg::addr_t exp_q[$];

    // reference copy of the cache state
    logic [TAG_W-1:0] tag_m [2][SETS];
    logic             valid_m [2][SETS];
    logic             lru_m [SETS];

    icache_top #(.INDEX_W(INDEX_W)) icache_top_inst (
        .clk(clk), .reset(reset),
        .fetch_en_i(fetch_en_i), .fetch_pc_i(fetch_pc_i), .fetch_uncache_i(fetch_uncache_i),
        .flush_i(flush_i), .stall_o(stall_o),
        .inst_valid_o(inst_valid_o), .inst_o(inst_o), .inst_pc_o(inst_pc_o),
        .rd_req_o(rd_req_o), .rd_addr_o(rd_addr_o),
        .ret_valid_i(ret_valid_i), .ret_data_i(ret_data_i),
        .uc_ren_o(uc_ren_o), .uc_addr_o(uc_addr_o),
        .uc_rvalid_i(uc_rvalid_i), .uc_rdata_i(uc_rdata_i),
        .cacop_en_i(cacop_en_i), .cacop_mode_i(cacop_mode_i), .cacop_addr_i(cacop_addr_i)
    );

    icache_tb_mem mem_inst (
        .clk(clk), .reset(reset), .lat_i(mem_lat),
        .rd_req_i(rd_req_o), .rd_addr_i(rd_addr_o),
        .ret_valid_o(ret_valid_i), .ret_data_o(ret_data_i),
        .uc_ren_i(uc_ren_o), .uc_addr_i(uc_addr_o),
        .uc_rvalid_o(uc_rvalid_i), .uc_rdata_o(uc_rdata_i)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
        return {a[24:0], a[31:25]} ^ 32'h5a3c_96e1;  // rotate left 7, then mix
    endfunction

    function automatic icache_pkg::addr_t make_pc(input logic [1:0] t, input logic [2:0] idx,
                                                  input logic [2:0] w);
        return {22'h0e5a71, t, idx, w, 2'b00};
    endfunction

    function automatic int model_hit_way(input icache_pkg::addr_t pc);
        logic [INDEX_W-1:0] idx;
        idx = pc[icache_pkg::OFFSET_W +: INDEX_W];
        for (int w = 0; w < 2; w++) begin
            if (valid_m[w][idx] && tag_m[w][idx] == pc[31 -: TAG_W]) return w;
        end
        return -1;  // miss
    endfunction

    function automatic void model_update(input icache_pkg::addr_t pc, input int way);
        logic [INDEX_W-1:0] idx;
        int                 w;
        idx = pc[icache_pkg::OFFSET_W +: INDEX_W];
        if (way >= 0) begin
            lru_m[idx] = (way == 0);
        end else begin
            w = lru_m[idx];
            tag_m[w][idx]   = pc[31 -: TAG_W];
            valid_m[w][idx] = 1'b1;
            lru_m[idx]      = (w == 0);
        end
    endfunction

    task automatic fail_now(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_inst(input icache_pkg::word_t got, input icache_pkg::word_t exp,
                              input icache_pkg::addr_t got_pc, input icache_pkg::addr_t exp_pc);
        if (got !== exp || got_pc !== exp_pc) begin
            fail_now($sformatf("inst %h at pc %h, expected %h at pc %h",
                               got, got_pc, exp, exp_pc));
        end
    endtask

    task automatic check_miss(input icache_pkg::addr_t got, input icache_pkg::addr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("memory request to %h, expected %h", got, exp));
        end
    endtask

    // results are checked in fetch order
    always @(negedge clk) begin
        if (!reset) begin
            if (rd_req_o && !rd_seen) begin
                rd_seen      = 1'b1;
                rd_seen_addr = rd_addr_o;
            end
            if (uc_ren_o && !uc_seen) begin
                uc_seen      = 1'b1;
                uc_seen_addr = uc_addr_o;
            end
            if (inst_valid_o) begin
                if (exp_q.size() == 0) begin
                    fail_now("instruction returned with no fetch outstanding");
                end else begin
                    check_inst(inst_o, expected_word(exp_q[0]), inst_pc_o, exp_q[0]);
                    void'(exp_q.pop_front());
                    prev_res_cyc = res_cyc;
                    res_cyc      = cyc;
                end
            end
        end
    end

    task automatic wait_accept(output int pre);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timed_out("stall_o to drop before a request");
        end while (stall_o);
        pre = cyc;
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) timed_out("inst_valid_o of an outstanding fetch");
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timed_out("stall_o to drop after an operation");
        end while (stall_o);
    endtask

    task automatic drive_fetch(input icache_pkg::addr_t pc, input logic unc);
        @(posedge clk);
        fetch_en_i      <= 1'b1;
        fetch_pc_i      <= pc;
        fetch_uncache_i <= unc;
        mem_lat         <= rand_bits(3);
    endtask

    task automatic do_fetch(input icache_pkg::addr_t pc, input logic unc);
        int way;
        int pre;
        way     = unc ? -1 : model_hit_way(pc);
        rd_seen = 1'b0;
        uc_seen = 1'b0;
        drive_fetch(pc, unc);
        wait_accept(pre);
        exp_q.push_back(pc);
        @(posedge clk);
        fetch_en_i <= 1'b0;
        wait_results();
        if (unc) begin
            if (!uc_seen || rd_seen) fail_now("uncached fetch did not use the uncached port");
            check_miss(uc_seen_addr, pc);
        end else if (way >= 0) begin
            if (rd_seen || uc_seen) fail_now("predicted hit went to memory");
            if (res_cyc - pre != 3) fail_now("hit result not two cycles after acceptance");
        end else begin
            if (!rd_seen) fail_now("predicted miss raised no rd_req_o");
            check_miss(rd_seen_addr, {pc[31:icache_pkg::OFFSET_W], 5'b0});
        end
        if (!unc) model_update(pc, way);
        wait_idle();
    endtask

    // two back to back fetches, both must hit
    task automatic pair_hits(input icache_pkg::addr_t a, input icache_pkg::addr_t b);
        int pre;
        if (model_hit_way(a) < 0 || model_hit_way(b) < 0) begin
            do_fetch(a, 1'b0);
            do_fetch(b, 1'b0);
        end else begin
            rd_seen = 1'b0;
            model_update(a, model_hit_way(a));
            model_update(b, model_hit_way(b));
            drive_fetch(a, 1'b0);
            wait_accept(pre);
            exp_q.push_back(a);
            @(posedge clk);
            fetch_pc_i <= b;
            @(negedge clk);
            if (stall_o) fail_now("stall_o high behind a hit");
            exp_q.push_back(b);
            @(posedge clk);
            fetch_en_i <= 1'b0;
            wait_results();
            if (rd_seen) fail_now("back to back hits went to memory");
            if (res_cyc - prev_res_cyc != 1 || res_cyc - pre != 4) begin
                fail_now("back to back hits not on consecutive cycles");
            end
        end
    endtask

    task automatic do_cacop(input icache_pkg::addr_t addr, input icache_pkg::cacop_mode_t mode);
        int pre;
        logic [INDEX_W-1:0] idx;
        idx = addr[icache_pkg::OFFSET_W +: INDEX_W];
        @(posedge clk);
        cacop_en_i   <= 1'b1;
        cacop_mode_i <= mode;
        cacop_addr_i <= addr;
        wait_accept(pre);
        @(posedge clk);
        cacop_en_i <= 1'b0;
        @(negedge clk);
        if (stall_o !== (mode != 2'd3)) fail_now("cacop stall_o wrong in the cacop cycle");
        @(negedge clk);
        if (stall_o) fail_now("cacop stall longer than one cycle");
        wait_idle();
        if (mode != 2'd3) begin
            valid_m[0][idx] = 1'b0;
            valid_m[1][idx] = 1'b0;
        end
    endtask

    // kill an outstanding miss, then fetch the same address again
    task automatic do_flush_miss(input icache_pkg::addr_t pc);
        int pre;
        int n;
        drive_fetch(pc, 1'b0);
        wait_accept(pre);
        @(posedge clk);
        fetch_en_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timed_out("rd_req_o of the fetch to be flushed");
        end while (!rd_req_o);
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        wait_idle();
        do_fetch(pc, 1'b0);
    endtask

    initial begin
        icache_pkg::addr_t pc;
        logic [3:0]        op;
        reset           = 1'b1;
        fetch_en_i      = 1'b0;
        fetch_pc_i      = '0;
        fetch_uncache_i = 1'b0;
        flush_i         = 1'b0;
        cacop_en_i      = 1'b0;
        cacop_mode_i    = '0;
        cacop_addr_i    = '0;
        mem_lat         = '0;
        cyc             = 0;
        res_cyc         = 0;
        prev_res_cyc    = 0;
        rd_seen         = 1'b0;
        uc_seen         = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            valid_m[0][s] = 1'b0;
            valid_m[1][s] = 1'b0;
            lru_m[s]      = 1'b0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        do_fetch(make_pc(2'd0, 3'd1, 3'd2), 1'b0);         // miss, then the line hits
        pair_hits(make_pc(2'd0, 3'd1, 3'd5), make_pc(2'd0, 3'd1, 3'd2));
        do_fetch(make_pc(2'd0, 3'd2, 3'd0), 1'b0);         // lru eviction in set 2
        do_fetch(make_pc(2'd1, 3'd2, 3'd1), 1'b0);
        do_fetch(make_pc(2'd0, 3'd2, 3'd3), 1'b0);
        do_fetch(make_pc(2'd2, 3'd2, 3'd4), 1'b0);
        do_fetch(make_pc(2'd0, 3'd2, 3'd6), 1'b0);
        do_fetch(make_pc(2'd1, 3'd2, 3'd7), 1'b0);
        do_fetch(make_pc(2'd0, 3'd1, 3'd3), 1'b1);         // uncached to a resident line
        do_fetch(make_pc(2'd0, 3'd1, 3'd3), 1'b0);
        do_cacop(make_pc(2'd3, 3'd1, 3'd0), 2'd3);
        do_fetch(make_pc(2'd0, 3'd1, 3'd4), 1'b0);
        do_cacop(make_pc(2'd3, 3'd1, 3'd0), 2'd1);
        do_fetch(make_pc(2'd0, 3'd1, 3'd4), 1'b0);
        do_flush_miss(make_pc(2'd3, 3'd6, 3'd1));

        for (int i = 0; i < 400; i++) begin
            op = rand_bits(4);
            pc = make_pc(rand_bits(2), rand_bits(3), rand_bits(3));
            if (op == 4'd0) begin
                do_fetch(pc, 1'b1);
            end else if (op == 4'd1) begin
                do_cacop(pc, rand_bits(2));
            end else if (op == 4'd2 && model_hit_way(pc) < 0) begin
                do_flush_miss(pc);
            end else if (op == 4'd3) begin
                pair_hits(pc, pc ^ 32'h4);
            end else begin
                do_fetch(pc, 1'b0);
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verification/icache_tb_mem.sv ====
`timescale 1ns/1ps

module icache_tb_mem (
    input  logic              clk,
    input  logic              reset,
    input  logic [2:0]        lat_i,        // extra wait cycles, from the testbench lfsr
    input  logic              rd_req_i,
    input  icache_pkg::addr_t rd_addr_i,
    output logic              ret_valid_o,
    output icache_pkg::line_t ret_data_o,
    input  logic              uc_ren_i,
    input  icache_pkg::addr_t uc_addr_i,
    output logic              uc_rvalid_o,
    output icache_pkg::word_t uc_rdata_o
);

    localparam icache_pkg::word_t MIX = 32'h5a3c_96e1;

    logic              busy;
    logic              is_uc;
    logic [3:0]        cnt;
    icache_pkg::addr_t addr_q;

    // word at byte address a
    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a);
        return {a[24:0], a[31:25]} ^ MIX;
    endfunction

    function automatic icache_pkg::line_t mem_line(input icache_pkg::addr_t base);
        icache_pkg::line_t l;
        for (int i = 0; i < icache_pkg::WORDS_PER_LINE; i++) begin
            l[i*32 +: 32] = mem_word(base + 4 * i);
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            is_uc       <= 1'b0;
            cnt         <= '0;
            addr_q      <= '0;
            ret_valid_o <= 1'b0;
            ret_data_o  <= '0;
            uc_rvalid_o <= 1'b0;
            uc_rdata_o  <= '0;
        end else begin
            ret_valid_o <= 1'b0;
            uc_rvalid_o <= 1'b0;
            if (!busy) begin
                // a request is still high in its return cycle, skip it there
                if (rd_req_i && !ret_valid_o) begin
                    busy   <= 1'b1;
                    is_uc  <= 1'b0;
                    addr_q <= rd_addr_i;
                    cnt    <= lat_i + 4'd1;
                end else if (uc_ren_i && !uc_rvalid_o) begin
                    busy   <= 1'b1;
                    is_uc  <= 1'b1;
                    addr_q <= uc_addr_i;
                    cnt    <= lat_i + 4'd1;
                end
            end else if (cnt > 4'd1) begin
                cnt <= cnt - 4'd1;
            end else begin
                busy <= 1'b0;
                if (is_uc) begin
                    uc_rvalid_o <= 1'b1;
                    uc_rdata_o  <= mem_word(addr_q);
                end else begin
                    ret_valid_o <= 1'b1;
                    ret_data_o  <= mem_line(addr_q);
                end
            end
        end
    end

endmodule
